// ==== design/sv39_pkg.sv ====
package sv39_pkg;

    // Sv39 geometry
    localparam int unsigned VA_W          = 39;
    localparam int unsigned PA_W          = 56;
    localparam int unsigned PPN_W         = 44;
    localparam int unsigned VPN_SEG_W     = 9;
    localparam int unsigned PAGE_OFFSET_W = 12;
    localparam int unsigned PTE_W         = 64;

    // Address and tag types
    typedef logic [VA_W-1:0]        vaddr_t;
    typedef logic [PA_W-1:0]        paddr_t;
    typedef logic [PPN_W-1:0]       ppn_t;
    typedef logic [3*VPN_SEG_W-1:0] vpn_t;
    typedef logic [19:0]            pscid_t;
    typedef logic [11:0]            cause_t;

    // Fault causes reported with the error pulse
    localparam cause_t CAUSE_LOAD_PF    = 12'd13;
    localparam cause_t CAUSE_STORE_PF   = 12'd15;
    localparam cause_t CAUSE_PT_CORRUPT = 12'd274;

    // PTE layout, bits 63:54 are split into reserved and pbmt
    // Neither is implemented, so both count as reserved
    typedef struct packed {
        logic [7:0] reserved;
        logic [1:0] pbmt;
        ppn_t       ppn;
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_t;

    // Walk level, LVL1 is the root table
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } ptw_level_e;

    // Outcome of one PTE check
    typedef enum logic [1:0] {
        PTE_NEXT,
        PTE_LEAF,
        PTE_FAULT
    } pte_kind_e;

    typedef struct packed {
        logic   valid;
        vaddr_t iova;
        pscid_t pscid;
        logic   is_store;
    } walk_req_t;

    typedef struct packed {
        vaddr_t iova;
        pscid_t pscid;
        logic   is_store;
    } walk_ctx_t;

    typedef struct packed {
        logic   valid;
        vpn_t   vpn;
        pscid_t pscid;
        logic   is_2m;
        logic   is_1g;
        pte_t   pte;
    } iotlb_update_t;

    typedef struct packed {
        logic   valid;
        cause_t cause;
    } walk_err_t;

endpackage

// ==== design/axil_pkg.sv ====
package axil_pkg;

    // Read data bus carries one PTE per beat
    localparam int unsigned AXIL_DATA_W = 64;

    typedef logic [1:0] axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // Read address channel, driven by the walker
    typedef struct packed {
        logic            valid;
        sv39_pkg::paddr_t addr;
        logic [2:0]      prot;
    } axil_ar_t;

    // Read data channel, driven by memory
    typedef struct packed {
        logic                   valid;
        logic [AXIL_DATA_W-1:0] data;
        axil_resp_t             resp;
    } axil_r_t;

endpackage

// ==== design/ptw_pte_check.sv ====
`timescale 1ns/1ps

module ptw_pte_check import sv39_pkg::*; (
    input  pte_t       pte_i,
    input  ptw_level_e level_i,
    input  logic       is_store_i,
    output pte_kind_e  kind_o
);

    logic is_leaf;
    logic bad_enc;
    logic bad_rsvd;
    logic bad_next;
    logic misaligned;
    logic bad_leaf;

    // Leaf when any of R or X is set
    assign is_leaf = pte_i.r | pte_i.x;

    // Invalid entry or the reserved W-only encoding
    assign bad_enc = !pte_i.v || (pte_i.w && !pte_i.r);

    // Bits 63:54 must be zero
    assign bad_rsvd = (|pte_i.reserved) || (|pte_i.pbmt);

    // Pointer PTEs keep A, D and U clear
    // and cannot appear below the last level
    assign bad_next = pte_i.a || pte_i.d || pte_i.u || (level_i == LVL3);

    // Superpage ppn must be aligned to the page size
    always_comb begin
        misaligned = 1'b0;
        if (level_i == LVL1) begin
            misaligned = |pte_i.ppn[2*VPN_SEG_W-1:0];
        end else if (level_i == LVL2) begin
            misaligned = |pte_i.ppn[VPN_SEG_W-1:0];
        end
    end

    // No hardware A/D update, so a clear A or a clean page on a store faults
    // Execute-only leaves fault too, every IOMMU access reads
    assign bad_leaf = misaligned || !pte_i.a || !pte_i.r || (is_store_i && !pte_i.d);

    always_comb begin
        if (bad_enc || bad_rsvd) begin
            kind_o = PTE_FAULT;
        end else if (is_leaf) begin
            kind_o = bad_leaf ? PTE_FAULT : PTE_LEAF;
        end else begin
            kind_o = bad_next ? PTE_FAULT : PTE_NEXT;
        end
    end

endmodule

// ==== design/ptw_walk_fsm.sv ====
`timescale 1ns/1ps

module ptw_walk_fsm import sv39_pkg::*; import axil_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  walk_req_t  walk_req_i,
    input  ppn_t       satp_ppn_i,
    output axil_ar_t   ar_o,
    input  logic       ar_ready_i,
    input  axil_r_t    r_i,
    output logic       r_ready_o,
    input  pte_kind_e  kind_i,
    output walk_ctx_t  ctx_o,
    output ptw_level_e level_o,
    output logic       start_o,
    output logic       pte_seen_o,
    output logic       bus_err_o,
    output logic       leaf_done_o,
    output logic       err_valid_o,
    output logic       active_o
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        PROPAGATE_ERROR
    } state_e;

    state_e     state_q, state_n;
    ptw_level_e level_q, level_n;
    walk_ctx_t  ctx_q, ctx_n;
    paddr_t     pptr_q, pptr_n;

    pte_t pte;
    logic r_fire;
    logic resp_ok;

    // Picks VPN[idx] out of an IO virtual address
    function automatic logic [VPN_SEG_W-1:0] vpn_seg(vaddr_t va, logic [1:0] idx);
        logic [VPN_SEG_W-1:0] seg;
        seg = va[PAGE_OFFSET_W + idx * VPN_SEG_W +: VPN_SEG_W];
        return seg;
    endfunction

    assign pte     = pte_t'(r_i.data[PTE_W-1:0]);
    assign r_fire  = r_ready_o && r_i.valid;
    assign resp_ok = (r_i.resp == RESP_OKAY);

    // AR channel driven straight from the registered pointer
    assign ar_o.valid = (state_q == WAIT_GRANT);
    assign ar_o.addr  = pptr_q;
    assign ar_o.prot  = 3'b000;

    // Always ready while waiting for the PTE
    assign r_ready_o = (state_q == PTE_LOOKUP);

    // Events for the result block
    assign start_o     = (state_q == IDLE) && walk_req_i.valid;
    assign pte_seen_o  = r_fire && resp_ok;
    assign bus_err_o   = r_fire && !resp_ok;
    assign leaf_done_o = pte_seen_o && (kind_i == PTE_LEAF);
    assign err_valid_o = (state_q == PROPAGATE_ERROR);
    assign active_o    = (state_q != IDLE);

    assign ctx_o   = ctx_q;
    assign level_o = level_q;

    always_comb begin
        logic [1:0] next_idx;
        state_n  = state_q;
        level_n  = level_q;
        ctx_n    = ctx_q;
        pptr_n   = pptr_q;
        // Segment that indexes the next table
        next_idx = (level_q == LVL1) ? 2'd1 : 2'd0;
        unique case (state_q)
            IDLE: begin
                if (walk_req_i.valid) begin
                    ctx_n.iova     = walk_req_i.iova;
                    ctx_n.pscid    = walk_req_i.pscid;
                    ctx_n.is_store = walk_req_i.is_store;
                    level_n        = LVL1;
                    // Root table from satp with 8-byte PTEs
                    pptr_n  = {satp_ppn_i, vpn_seg(walk_req_i.iova, 2'd2), 3'b000};
                    state_n = WAIT_GRANT;
                end
            end
            WAIT_GRANT: begin
                if (ar_ready_i) begin
                    state_n = PTE_LOOKUP;
                end
            end
            PTE_LOOKUP: begin
                if (r_fire) begin
                    if (!resp_ok) begin
                        // Bus error wins over any PTE check
                        state_n = PROPAGATE_ERROR;
                    end else begin
                        unique case (kind_i)
                            PTE_NEXT: begin
                                level_n = (level_q == LVL1) ? LVL2 : LVL3;
                                pptr_n  = {pte.ppn, vpn_seg(ctx_q.iova, next_idx), 3'b000};
                                state_n = WAIT_GRANT;
                            end
                            PTE_LEAF: begin
                                state_n = IDLE;
                            end
                            default: begin
                                state_n = PROPAGATE_ERROR;
                            end
                        endcase
                    end
                end
            end
            PROPAGATE_ERROR: begin
                // One-cycle error pulse before going idle
                state_n = IDLE;
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            level_q <= LVL1;
        end else begin
            state_q <= state_n;
            level_q <= level_n;
        end
    end

    // Walk payload
    always_ff @(posedge clk_i) begin
        ctx_q  <= ctx_n;
        pptr_q <= pptr_n;
    end

    // Read data only arrives for the one outstanding AR
    r_resp_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_i.valid |-> (state_q == PTE_LOOKUP));

    // The checker never lets a pointer PTE through at the last level
    last_level_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pte_seen_o && (level_q == LVL3) |-> (kind_i != PTE_NEXT));

endmodule

// ==== design/ptw_result.sv ====
`timescale 1ns/1ps

module ptw_result import sv39_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  walk_ctx_t     ctx_i,
    input  ptw_level_e    level_i,
    input  pte_t          pte_i,
    input  logic          start_i,
    input  logic          pte_seen_i,
    input  logic          bus_err_i,
    input  logic          leaf_done_i,
    input  logic          err_valid_i,
    output iotlb_update_t iotlb_up_o,
    output walk_err_t     walk_err_o
);

    logic   global_q;
    cause_t cause_q;

    // Global mapping sticks once any PTE of the walk has G set
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            global_q <= 1'b0;
        end else if (start_i) begin
            global_q <= 1'b0;
        end else if (pte_seen_i && pte_i.g) begin
            global_q <= 1'b1;
        end
    end

    // Cause latched on each R handshake and read in the error cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cause_q <= '0;
        end else if (bus_err_i) begin
            cause_q <= CAUSE_PT_CORRUPT;
        end else if (pte_seen_i) begin
            cause_q <= ctx_i.is_store ? CAUSE_STORE_PF : CAUSE_LOAD_PF;
        end
    end

    // IOTLB entry built from the leaf on the bus
    always_comb begin
        iotlb_up_o.valid = leaf_done_i;
        iotlb_up_o.vpn   = ctx_i.iova[VA_W-1:PAGE_OFFSET_W];
        iotlb_up_o.pscid = ctx_i.pscid;
        // Leaf level gives the page size
        iotlb_up_o.is_1g = (level_i == LVL1);
        iotlb_up_o.is_2m = (level_i == LVL2);
        iotlb_up_o.pte   = pte_i;
        iotlb_up_o.pte.g = pte_i.g | global_q;
    end

    assign walk_err_o.valid = err_valid_i;
    assign walk_err_o.cause = cause_q;

    // A superpage update always carries a ppn aligned to its size
    up_align_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        iotlb_up_o.valid |-> !(iotlb_up_o.is_1g && (|iotlb_up_o.pte.ppn[2*VPN_SEG_W-1:0]))
            && !(iotlb_up_o.is_2m && (|iotlb_up_o.pte.ppn[VPN_SEG_W-1:0])));

endmodule

// ==== design/ptw_sv39.sv ====
`timescale 1ns/1ps

module ptw_sv39 import sv39_pkg::*; import axil_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  walk_req_t     walk_req_i,
    input  ppn_t          satp_ppn_i,
    output logic          ptw_active_o,
    output axil_ar_t      ar_o,
    input  logic          ar_ready_i,
    input  axil_r_t       r_i,
    output logic          r_ready_o,
    output iotlb_update_t iotlb_up_o,
    output walk_err_t     walk_err_o
);

    pte_t       pte;
    pte_kind_e  kind;
    walk_ctx_t  ctx;
    ptw_level_e level;
    logic       start;
    logic       pte_seen;
    logic       bus_err;
    logic       leaf_done;
    logic       err_valid;

    // Read data seen as a PTE
    assign pte = pte_t'(r_i.data[PTE_W-1:0]);

    ptw_walk_fsm u_walk_fsm (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .walk_req_i  (walk_req_i),
        .satp_ppn_i  (satp_ppn_i),
        .ar_o        (ar_o),
        .ar_ready_i  (ar_ready_i),
        .r_i         (r_i),
        .r_ready_o   (r_ready_o),
        .kind_i      (kind),
        .ctx_o       (ctx),
        .level_o     (level),
        .start_o     (start),
        .pte_seen_o  (pte_seen),
        .bus_err_o   (bus_err),
        .leaf_done_o (leaf_done),
        .err_valid_o (err_valid),
        .active_o    (ptw_active_o)
    );

    ptw_pte_check u_pte_check (
        .pte_i      (pte),
        .level_i    (level),
        .is_store_i (ctx.is_store),
        .kind_o     (kind)
    );

    ptw_result u_result (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .ctx_i       (ctx),
        .level_i     (level),
        .pte_i       (pte),
        .start_i     (start),
        .pte_seen_i  (pte_seen),
        .bus_err_i   (bus_err),
        .leaf_done_i (leaf_done),
        .err_valid_i (err_valid),
        .iotlb_up_o  (iotlb_up_o),
        .walk_err_o  (walk_err_o)
    );

endmodule

// ==== sim/tb_ptw_sv39.sv ====
`timescale 1ns/1ps

module tb_ptw_sv39 import sv39_pkg::*; import axil_pkg::*; ();

    // Table layout used by every test
    localparam ppn_t   SATP     = 44'h100;
    localparam ppn_t   T2       = 44'h200;
    localparam ppn_t   T3       = 44'h300;
    localparam ppn_t   LEAF_PPN = 44'h12345;
    localparam pscid_t PSCID    = 20'hABCDE;
    localparam vaddr_t VA_A     = 39'h3C_1234_5678;
    localparam vaddr_t VA_B     = 39'h11_8765_4321;

    // PTE flag bytes as {d, a, g, u, x, w, r, v}
    localparam logic [7:0] F_PTR     = 8'h01;
    localparam logic [7:0] F_PTR_G   = 8'h21;
    localparam logic [7:0] F_PTR_A   = 8'h41;
    localparam logic [7:0] F_RW      = 8'hC7;
    localparam logic [7:0] F_CLEAN   = 8'h47;
    localparam logic [7:0] F_W_ONLY  = 8'hC5;
    localparam logic [7:0] F_INVALID = 8'hC6;

    localparam logic [11:0] LOAD_PF  = 12'd13;
    localparam logic [11:0] STORE_PF = 12'd15;
    localparam logic [11:0] CORRUPT  = 12'd274;

    // Run length limits
    localparam int N_WALKS     = 13;
    localparam int LEVEL_CYC   = 10;
    localparam int MARGIN      = 4;
    localparam int WALK_LIMIT  = 3 * LEVEL_CYC * 2;
    localparam int WATCHDOG_NS = N_WALKS * 3 * LEVEL_CYC * MARGIN * 20;

    logic          clk_i;
    logic          rst_ni;
    walk_req_t     walk_req_i;
    ppn_t          satp_ppn_i;
    logic          ptw_active_o;
    axil_ar_t      ar_o;
    logic          ar_ready_i = 1'b0;
    axil_r_t       r_i = '0;
    logic          r_ready_o;
    iotlb_update_t iotlb_up_o;
    walk_err_t     walk_err_o;

    // Memory model and its error injection
    logic [63:0] mem [paddr_t];
    logic        err_en;
    paddr_t      err_addr;

    // Responder state
    logic [15:0] lfsr = 16'd79;
    int unsigned ar_wait = 0;
    int unsigned r_wait = 0;
    logic        r_pend = 1'b0;
    paddr_t      r_addr;

    // Monitor results
    int            cyc = 0;
    int            r_cyc = 0;
    int            up_cnt = 0;
    int            err_cnt = 0;
    int            err_gap = 0;
    iotlb_update_t up_seen;
    walk_err_t     err_seen;
    paddr_t        ar_q[$];
    logic          hold_chk = 1'b0;
    paddr_t        hold_addr;
    logic          idle_chk = 1'b0;

    int val_errs = 0;
    int mon_errs = 0;
    int timeouts = 0;
    int up_base;
    int err_base;
    int ar_base;

    ptw_sv39 DUT (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .walk_req_i   (walk_req_i),
        .satp_ppn_i   (satp_ppn_i),
        .ptw_active_o (ptw_active_o),
        .ar_o         (ar_o),
        .ar_ready_i   (ar_ready_i),
        .r_i          (r_i),
        .r_ready_o    (r_ready_o),
        .iotlb_up_o   (iotlb_up_o),
        .walk_err_o   (walk_err_o)
    );

    always #10 clk_i = ~clk_i;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Two LFSR bits give a stall of 0 to 3 cycles
    task automatic draw_delay(output int unsigned d);
        d = 0;
        repeat (2) begin
            lfsr = lfsr_step(lfsr);
            d = {d[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [63:0] make_pte(input ppn_t ppn, input logic [7:0] flags);
        return {10'b0, ppn, 2'b00, flags};
    endfunction

    // Entry address for level lvl is table base times 4096 plus VPN segment times 8
    function automatic paddr_t slot(input ppn_t tbl, input vaddr_t va, input int unsigned lvl);
        vaddr_t idx;
        idx = (va >> (12 + 9 * (3 - lvl))) & 39'h1ff;
        return paddr_t'(tbl) * 4096 + paddr_t'(idx) * 8;
    endfunction

    // AXI4-Lite slave with random AR and R stalls
    always @(posedge clk_i) begin
        if (!rst_ni) begin
            ar_ready_i <= 1'b0;
            r_i        <= '0;
            r_pend = 1'b0;
        end else begin
            if (ar_o.valid && ar_ready_i) begin
                ar_ready_i <= 1'b0;
                r_addr = ar_o.addr;
                r_pend = 1'b1;
                draw_delay(r_wait);
                draw_delay(ar_wait);
            end else if (ar_o.valid) begin
                if (ar_wait == 0) begin
                    ar_ready_i <= 1'b1;
                end else begin
                    ar_wait--;
                end
            end
            if (r_i.valid && r_ready_o) begin
                r_i <= '0;
            end else if (r_pend) begin
                if (r_wait == 0) begin
                    r_i.valid <= 1'b1;
                    r_i.data  <= mem.exists(r_addr) ? mem[r_addr] : 64'h0;
                    r_i.resp  <= (err_en && r_addr == err_addr) ? RESP_SLVERR : RESP_OKAY;
                    r_pend = 1'b0;
                end else begin
                    r_wait--;
                end
            end
        end
    end

    // Sampled mid-cycle where DUT outputs are settled
    always @(negedge clk_i) begin
        if (rst_ni) begin
            cyc++;
            if (hold_chk) begin
                assert (ar_o.valid && ar_o.addr === hold_addr) else begin
                    $display("AR request was withdrawn or changed before it was accepted");
                    mon_errs++;
                end
            end
            hold_chk  = ar_o.valid && !ar_ready_i;
            hold_addr = ar_o.addr;
            if (ar_o.valid && ar_ready_i) begin
                ar_q.push_back(ar_o.addr);
                check_val("ar_o.prot", 64'(ar_o.prot), 64'd0);
            end
            if (r_i.valid && r_ready_o) begin
                r_cyc = cyc;
            end
            // Walker drops back to idle right after its update or error
            if (idle_chk) begin
                assert (!ptw_active_o) else begin
                    $display("Walker still active in the cycle after its update or error");
                    mon_errs++;
                end
            end
            idle_chk = iotlb_up_o.valid || walk_err_o.valid;
            if (iotlb_up_o.valid) begin
                up_cnt++;
                up_seen = iotlb_up_o;
                assert (r_i.valid && r_ready_o) else begin
                    $display("IOTLB update pulse came outside the final read handshake");
                    mon_errs++;
                end
            end
            if (walk_err_o.valid) begin
                err_cnt++;
                err_seen = walk_err_o;
                err_gap  = cyc - r_cyc;
            end
        end
    end

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
            val_errs++;
        end
    endtask

    task automatic set_tables(input vaddr_t va, input logic [63:0] e1, e2, e3);
        mem.delete();
        mem[slot(SATP, va, 1)] = e1;
        mem[slot(T2, va, 2)]   = e2;
        mem[slot(T3, va, 3)]   = e3;
    endtask

    // Issues one request plus an optional second one while busy and waits for the outcome
    task automatic do_walk(input vaddr_t va, input logic st, input logic dup);
        int n;
        up_base  = up_cnt;
        err_base = err_cnt;
        ar_base  = ar_q.size();
        @(posedge clk_i);
        walk_req_i <= '{valid: 1'b1, iova: va, pscid: PSCID, is_store: st};
        @(posedge clk_i);
        walk_req_i.valid <= 1'b0;
        if (dup) begin
            repeat (2) @(posedge clk_i);
            walk_req_i <= '{valid: 1'b1, iova: VA_B, pscid: 20'h1, is_store: 1'b0};
            @(posedge clk_i);
            walk_req_i.valid <= 1'b0;
        end
        n = 0;
        while (up_cnt == up_base && err_cnt == err_base && n < WALK_LIMIT) begin
            @(posedge clk_i);
            n++;
        end
        if (up_cnt == up_base && err_cnt == err_base) begin
            $display("Walk for iova 0x%0h did not finish in %0d cycles", va, WALK_LIMIT);
            timeouts++;
        end
        // Extra cycles so that a stray pulse is still counted
        repeat (4) @(posedge clk_i);
    endtask

    task automatic check_update(input vaddr_t va, input logic [63:0] pte, input logic g1,
                                input logic m2, input int reads);
        check_val("iotlb_up_o count", 64'(up_cnt - up_base), 64'd1);
        check_val("walk_err_o count", 64'(err_cnt - err_base), 64'd0);
        check_val("iotlb_up_o.vpn", 64'(up_seen.vpn), 64'(va[38:12]));
        check_val("iotlb_up_o.pscid", 64'(up_seen.pscid), 64'(PSCID));
        check_val("iotlb_up_o.is_1g", 64'(up_seen.is_1g), 64'(g1));
        check_val("iotlb_up_o.is_2m", 64'(up_seen.is_2m), 64'(m2));
        check_val("iotlb_up_o.pte", 64'(up_seen.pte), pte);
        check_val("AR count", 64'(ar_q.size() - ar_base), 64'(reads));
    endtask

    task automatic check_error(input logic [11:0] cause, input int reads);
        check_val("walk_err_o count", 64'(err_cnt - err_base), 64'd1);
        check_val("iotlb_up_o count", 64'(up_cnt - up_base), 64'd0);
        check_val("walk_err_o.cause", 64'(err_seen.cause), 64'(cause));
        check_val("error delay", 64'(err_gap), 64'd1);
        check_val("AR count", 64'(ar_q.size() - ar_base), 64'(reads));
    endtask

    task automatic test_reset_outputs();
        check_val("ptw_active_o", 64'(ptw_active_o), 64'd0);
        check_val("ar_o.valid", 64'(ar_o.valid), 64'd0);
        check_val("r_ready_o", 64'(r_ready_o), 64'd0);
        check_val("iotlb_up_o.valid", 64'(iotlb_up_o.valid), 64'd0);
        check_val("walk_err_o.valid", 64'(walk_err_o.valid), 64'd0);
    endtask

    // Three-level walk down to a 4 KiB leaf
    task automatic test_4k_walk(input logic st, input logic dup);
        logic [63:0] leaf;
        leaf = make_pte(LEAF_PPN, F_RW);
        set_tables(VA_A, make_pte(T2, F_PTR), make_pte(T3, F_PTR), leaf);
        do_walk(VA_A, st, dup);
        check_update(VA_A, leaf, 1'b0, 1'b0, 3);
        if (ar_q.size() >= ar_base + 3) begin
            check_val("ar_o.addr L1", 64'(ar_q[ar_base]), 64'(slot(SATP, VA_A, 1)));
            check_val("ar_o.addr L2", 64'(ar_q[ar_base + 1]), 64'(slot(T2, VA_A, 2)));
            check_val("ar_o.addr L3", 64'(ar_q[ar_base + 2]), 64'(slot(T3, VA_A, 3)));
        end
    endtask

    task automatic test_superpages();
        logic [63:0] leaf;
        leaf = make_pte(44'h40000, F_RW);
        set_tables(VA_B, leaf, 64'h0, 64'h0);
        do_walk(VA_B, 1'b0, 1'b0);
        check_update(VA_B, leaf, 1'b1, 1'b0, 1);
        leaf = make_pte(44'h1200, F_RW);
        set_tables(VA_A, make_pte(T2, F_PTR), leaf, 64'h0);
        do_walk(VA_A, 1'b1, 1'b0);
        check_update(VA_A, leaf, 1'b0, 1'b1, 2);
    endtask

    // G on the root pointer carries into the leaf entry
    task automatic test_global_bit();
        logic [63:0] leaf;
        leaf = make_pte(LEAF_PPN, F_RW);
        set_tables(VA_A, make_pte(T2, F_PTR_G), make_pte(T3, F_PTR), leaf);
        do_walk(VA_A, 1'b0, 1'b0);
        check_update(VA_A, leaf | 64'h20, 1'b0, 1'b0, 3);
    endtask

    task automatic expect_fault(input logic st, input logic [63:0] e1, e2, e3, input int reads);
        set_tables(VA_A, e1, e2, e3);
        do_walk(VA_A, st, 1'b0);
        check_error(st ? STORE_PF : LOAD_PF, reads);
    endtask

    task automatic test_pte_faults();
        logic [63:0] p1;
        logic [63:0] p2;
        p1 = make_pte(T2, F_PTR);
        p2 = make_pte(T3, F_PTR);
        expect_fault(1'b0, p1, p2, make_pte(LEAF_PPN, F_INVALID), 3);
        expect_fault(1'b1, p1, p2, make_pte(LEAF_PPN, F_W_ONLY), 3);
        // Bit 60 lies in the reserved field
        expect_fault(1'b0, p1, p2 | 64'h1000_0000_0000_0000, 64'h0, 2);
        expect_fault(1'b1, make_pte(T2, F_PTR_A), p2, 64'h0, 1);
        expect_fault(1'b0, p1, p2, make_pte(44'h400, F_PTR), 3);
        expect_fault(1'b0, p1, make_pte(44'h1201, F_RW), 64'h0, 2);
        expect_fault(1'b1, p1, p2, make_pte(LEAF_PPN, F_CLEAN), 3);
    endtask

    task automatic test_bus_error();
        err_en   = 1'b1;
        err_addr = slot(T2, VA_A, 2);
        set_tables(VA_A, make_pte(T2, F_PTR), make_pte(T3, F_PTR), make_pte(LEAF_PPN, F_RW));
        do_walk(VA_A, 1'b0, 1'b0);
        check_error(CORRUPT, 2);
        err_en = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests completed");
        $display("Verification failed");
        $finish;
    end

    initial begin
        clk_i      = 1'b0;
        rst_ni     = 1'b0;
        walk_req_i = '0;
        satp_ppn_i = SATP;
        err_en     = 1'b0;
        err_addr   = '0;
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        test_reset_outputs();
        test_4k_walk(1'b0, 1'b0);
        test_superpages();
        test_global_bit();
        test_pte_faults();
        test_bus_error();
        // Second request while busy must be dropped
        test_4k_walk(1'b1, 1'b1);
        $display("Errors: %0d value, %0d protocol, %0d timeout", val_errs, mon_errs, timeouts);
        if (val_errs + mon_errs + timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== ptw_sv39.f ====
design/sv39_pkg.sv
design/axil_pkg.sv
design/ptw_pte_check.sv
design/ptw_walk_fsm.sv
design/ptw_result.sv
design/ptw_sv39.sv
sim/tb_ptw_sv39.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the Sv39 walker testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_ptw_sv39 -f ptw_sv39.f -o tb_ptw_sv39 \
    && ./obj_dir/tb_ptw_sv39 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
if grep -q "Verification failed" sim.log; then
    exit 1
fi
grep -q "Verification passed" sim.log || exit 1
